// ==== source/mpa_pkg.sv ====
package mpa_pkg;

    // Multi-precision opcodes
    typedef enum logic [3:0] {
        OP_MEQU,
        OP_MLTE,
        OP_MGTE,
        OP_MADD2,
        OP_MADD3,
        OP_MSUB2,
        OP_MSUB3,
        OP_MACC1,
        OP_MACC2,
        OP_MMUL1,
        OP_MSLL,
        OP_MSLLI,
        OP_MSRL,
        OP_MSRLI
    } mpa_op_e;

    // Position within a multi-cycle operation
    typedef enum logic [1:0] {
        STEP0,
        STEP1,
        STEP2
    } mpa_step_e;

    typedef enum logic {
        LHS_RS1,
        LHS_TMP
    } mpa_lhs_sel_e;

    typedef enum logic [1:0] {
        RHS_RS2,
        RHS_RS3,
        RHS_PAIR                    // {rs2,rs3}
    } mpa_rhs_sel_e;

    typedef enum logic [1:0] {
        TMP_NONE,
        TMP_ADD,
        TMP_MUL,
        TMP_SHF
    } mpa_tmp_ld_e;

    typedef enum logic [2:0] {
        WB_NONE,
        WB_TMP_HI,
        WB_ADD_LO,
        WB_SHF_LO,
        WB_CMP
    } mpa_wb_sel_e;

    typedef struct packed {
        mpa_op_e     op;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] rs3;
        logic [5:0]  imm;           // Immediate shift amount
        logic        carry_in;      // Chained equality flag
    } mpa_req_t;

    typedef struct packed {
        mpa_lhs_sel_e lhs_sel;
        mpa_rhs_sel_e rhs_sel;
        logic         sub;
        logic         use_imm;
        logic         shift_right;
        mpa_tmp_ld_e  tmp_ld;
        mpa_wb_sel_e  wb_sel;
    } mpa_ctrl_t;

    typedef struct packed {
        logic [3:0]  ben;
        logic        word_hi;
        logic [31:0] wdata;
    } mpa_wb_t;

endpackage

// ==== source/mpa_sequencer.sv ====
`timescale 1ns/10ps

module mpa_sequencer import mpa_pkg::*; (
    input  logic      g_clk,
    input  logic      g_resetn,
    input  logic      req_valid_i,
    input  mpa_req_t  req_i,
    output mpa_req_t  req_o,
    output mpa_ctrl_t ctrl_o,
    output logic      done_o,
    output logic      busy_o,
    output logic      dest_in_rs_o
);

    logic      busy_q;
    mpa_step_e step_q;
    mpa_step_e last_step;
    mpa_req_t  req_q;
    mpa_ctrl_t ctrl;
    logic      accept;
    logic      done;

    // New work is taken when idle or in the final step of the current op
    assign accept = req_valid_i && (!busy_q || done);
    assign done   = busy_q && (step_q == last_step);

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            busy_q <= 1'b0;
            step_q <= STEP0;
        end else if (accept) begin
            busy_q <= 1'b1;
            step_q <= STEP0;
        end else if (done) begin
            busy_q <= 1'b0;
            step_q <= STEP0;        // Counter clears on completion
        end else if (busy_q) begin
            step_q <= mpa_step_e'(step_q + 2'd1);
        end
    end

    // Held operands stay stable for the whole operation
    always_ff @(posedge g_clk) begin
        if (accept) begin
            req_q <= req_i;
        end
    end

    // Control word for the current opcode and step
    always_comb begin
        ctrl      = '0;
        last_step = STEP0;
        if (busy_q) begin
            case (req_q.op)
                OP_MEQU, OP_MLTE, OP_MGTE: begin
                    ctrl.wb_sel = WB_CMP;   // Single step, one bit result
                end
                OP_MADD2, OP_MSUB2, OP_MACC1: begin
                    last_step    = STEP1;
                    ctrl.sub     = (req_q.op == OP_MSUB2);
                    ctrl.rhs_sel = (req_q.op == OP_MACC1) ? RHS_PAIR : RHS_RS2;
                    if (step_q == STEP0) begin
                        ctrl.tmp_ld = TMP_ADD;
                        ctrl.wb_sel = WB_ADD_LO;
                    end else begin
                        ctrl.wb_sel = WB_TMP_HI;
                    end
                end
                OP_MSLL, OP_MSLLI, OP_MSRL, OP_MSRLI: begin
                    last_step        = STEP1;
                    ctrl.use_imm     = (req_q.op == OP_MSLLI) || (req_q.op == OP_MSRLI);
                    ctrl.shift_right = (req_q.op == OP_MSRL) || (req_q.op == OP_MSRLI);
                    if (step_q == STEP0) begin
                        ctrl.tmp_ld = TMP_SHF;
                        ctrl.wb_sel = WB_SHF_LO;
                    end else begin
                        ctrl.wb_sel = WB_TMP_HI;
                    end
                end
                OP_MADD3, OP_MSUB3: begin
                    last_step = STEP2;
                    ctrl.sub  = (req_q.op == OP_MSUB3);
                    case (step_q)
                        STEP0: begin
                            ctrl.tmp_ld = TMP_ADD;          // rs1 +/- rs2
                        end
                        STEP1: begin
                            ctrl.lhs_sel = LHS_TMP;
                            ctrl.rhs_sel = RHS_RS3;
                            ctrl.tmp_ld  = TMP_ADD;
                            ctrl.wb_sel  = WB_ADD_LO;
                        end
                        default: ctrl.wb_sel = WB_TMP_HI;
                    endcase
                end
                OP_MACC2: begin
                    last_step = STEP2;
                    case (step_q)
                        STEP0: begin
                            ctrl.rhs_sel = RHS_PAIR;
                            ctrl.tmp_ld  = TMP_ADD;
                        end
                        STEP1: begin
                            ctrl.lhs_sel = LHS_TMP;         // Then add rs2
                            ctrl.tmp_ld  = TMP_ADD;
                            ctrl.wb_sel  = WB_ADD_LO;
                        end
                        default: ctrl.wb_sel = WB_TMP_HI;
                    endcase
                end
                OP_MMUL1: begin
                    last_step = STEP2;
                    case (step_q)
                        STEP0: ctrl.tmp_ld = TMP_MUL;
                        STEP1: begin
                            ctrl.lhs_sel = LHS_TMP;         // Product plus rs3
                            ctrl.rhs_sel = RHS_RS3;
                            ctrl.tmp_ld  = TMP_ADD;
                            ctrl.wb_sel  = WB_ADD_LO;
                        end
                        default: ctrl.wb_sel = WB_TMP_HI;
                    endcase
                end
                default: ;  // Unused encodings finish in one idle step
            endcase
        end
    end

    assign req_o        = req_q;
    assign ctrl_o       = ctrl;
    assign done_o       = done;
    assign busy_o       = busy_q;
    assign dest_in_rs_o = busy_q && ((req_q.op == OP_MACC1) || (req_q.op == OP_MACC2));

endmodule

// ==== source/mpa_arith_unit.sv ====
`timescale 1ns/10ps

module mpa_arith_unit import mpa_pkg::*; (
    input  mpa_req_t    req_i,
    input  mpa_ctrl_t   ctrl_i,
    input  logic [63:0] tmp_i,
    output logic [63:0] add_o,
    output logic [63:0] mul_o
);

    logic [63:0] add_lhs;
    logic [63:0] add_rhs;
    logic [63:0] mul_lhs;
    logic [63:0] mul_rhs;

    // Left operand is rs1 or the running partial result
    always_comb begin
        case (ctrl_i.lhs_sel)
            LHS_TMP: add_lhs = tmp_i;
            default: add_lhs = {32'b0, req_i.rs1};
        endcase
    end

    // Right operand, paired form for the accumulates
    always_comb begin
        case (ctrl_i.rhs_sel)
            RHS_RS2: begin
                add_rhs = {32'b0, req_i.rs2};
            end
            RHS_RS3: begin
                add_rhs = {32'b0, req_i.rs3};
            end
            RHS_PAIR: begin
                add_rhs = {req_i.rs2, req_i.rs3};
            end
            default: begin
                add_rhs = '0;
            end
        endcase
    end

    // Wraps modulo 2^64 on borrow
    always_comb begin
        if (ctrl_i.sub) begin
            add_o = add_lhs - add_rhs;
        end else begin
            add_o = add_lhs + add_rhs;
        end
    end

    // Full 64 bit product of two unsigned words
    assign mul_lhs = {32'b0, req_i.rs1};
    assign mul_rhs = {32'b0, req_i.rs2};
    assign mul_o   = mul_lhs * mul_rhs;

endmodule

// ==== source/mpa_shift_cmp_unit.sv ====
`timescale 1ns/10ps

module mpa_shift_cmp_unit import mpa_pkg::*; (
    input  mpa_req_t    req_i,
    input  mpa_ctrl_t   ctrl_i,
    output logic [63:0] shf_o,
    output logic        cmp_o
);

    logic [63:0] shf_src;
    logic [5:0]  shamt;
    logic        ret_zero;
    logic        cmp_eq;
    logic        cmp_lt;
    logic        cmp_gt;
    logic        eq_chain;

    assign shf_src  = {req_i.rs1, req_i.rs2};
    assign shamt    = ctrl_i.use_imm ? req_i.imm : req_i.rs3[5:0];
    assign ret_zero = !ctrl_i.use_imm && (|req_i.rs3[31:6]);   // Amount of 64 or more

    always_comb begin
        if (ret_zero) begin
            shf_o = '0;
        end else if (ctrl_i.shift_right) begin
            shf_o = shf_src >> shamt;
        end else begin
            shf_o = shf_src << shamt;
        end
    end

    // Unsigned word compare
    assign cmp_eq = (req_i.rs2 == req_i.rs3);
    assign cmp_lt = (req_i.rs2 <  req_i.rs3);
    assign cmp_gt = !cmp_eq && !cmp_lt;

    // Equal words pass the result of the previous word pair along
    assign eq_chain = cmp_eq && req_i.carry_in;

    always_comb begin
        case (req_i.op)
            OP_MEQU: cmp_o = eq_chain;
            OP_MLTE: cmp_o = cmp_lt || eq_chain;
            OP_MGTE: cmp_o = cmp_gt || eq_chain;
            default: cmp_o = 1'b0;
        endcase
    end

endmodule

// ==== source/mpa_writeback.sv ====
`timescale 1ns/10ps

module mpa_writeback import mpa_pkg::*; (
    input  logic        g_clk,
    input  logic        g_resetn,
    input  mpa_ctrl_t   ctrl_i,
    input  logic [63:0] add_i,
    input  logic [63:0] mul_i,
    input  logic [63:0] shf_i,
    input  logic        cmp_i,
    output logic [63:0] tmp_o,
    output logic        wb_valid_o,
    output mpa_wb_t     wb_o
);

    logic [63:0] tmp_q;
    mpa_wb_t     wb;

    // Partial result carried from one step to the next
    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            tmp_q <= '0;
        end else begin
            case (ctrl_i.tmp_ld)
                TMP_ADD: tmp_q <= add_i;
                TMP_MUL: tmp_q <= mul_i;
                TMP_SHF: tmp_q <= shf_i;
                default: ;
            endcase
        end
    end

    // Outgoing word
    always_comb begin
        wb = '0;
        case (ctrl_i.wb_sel)
            WB_TMP_HI: begin
                wb.wdata   = tmp_q[63:32];
                wb.word_hi = 1'b1;
            end
            WB_ADD_LO: begin
                wb.wdata = add_i[31:0];
            end
            WB_SHF_LO: begin
                wb.wdata = shf_i[31:0];
            end
            WB_CMP: begin
                wb.wdata = {31'b0, cmp_i};
            end
            default: ;
        endcase
        if (ctrl_i.wb_sel != WB_NONE) begin
            wb.ben = 4'hf;      // Whole word always
        end
    end

    assign tmp_o      = tmp_q;
    assign wb_o       = wb;
    assign wb_valid_o = (ctrl_i.wb_sel != WB_NONE);

endmodule

// ==== source/mpa_malu_top.sv ====
`timescale 1ns/10ps

module mpa_malu_top import mpa_pkg::*; (
    input  logic     g_clk,
    input  logic     g_resetn,
    input  logic     req_valid_i,
    input  mpa_req_t req_i,
    output logic     wb_valid_o,
    output mpa_wb_t  wb_o,
    output logic     done_o,
    output logic     busy_o,
    output logic     dest_in_rs_o
);

    mpa_req_t    req_q;
    mpa_ctrl_t   ctrl;
    logic [63:0] add_result;
    logic [63:0] mul_result;
    logic [63:0] shf_result;
    logic        cmp_bit;
    logic [63:0] tmp;

    mpa_sequencer u_sequencer (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .req_o        (req_q),
        .ctrl_o       (ctrl),
        .done_o       (done_o),
        .busy_o       (busy_o),
        .dest_in_rs_o (dest_in_rs_o)
    );

    mpa_arith_unit u_arith (
        .req_i  (req_q),
        .ctrl_i (ctrl),
        .tmp_i  (tmp),      // Fed back from the writeback stage
        .add_o  (add_result),
        .mul_o  (mul_result)
    );

    mpa_shift_cmp_unit u_shift_cmp (
        .req_i  (req_q),
        .ctrl_i (ctrl),
        .shf_o  (shf_result),
        .cmp_o  (cmp_bit)
    );

    mpa_writeback u_writeback (
        .g_clk      (g_clk),
        .g_resetn   (g_resetn),
        .ctrl_i     (ctrl),
        .add_i      (add_result),
        .mul_i      (mul_result),
        .shf_i      (shf_result),
        .cmp_i      (cmp_bit),
        .tmp_o      (tmp),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o)
    );

endmodule

// ==== test/mpa_malu_tb.sv ====
`timescale 1ns/10ps

module mpa_malu_tb import mpa_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int N_RAND       = 24;
    localparam int DONE_LIMIT   = 8;
    localparam int SEED         = 85;

    logic        g_clk;
    logic        g_resetn;
    logic        req_valid_i;
    mpa_req_t    req_i;
    logic        wb_valid_o;
    mpa_wb_t     wb_o;
    logic        done_o;
    logic        busy_o;
    logic        dest_in_rs_o;

    int          cyc;
    int          dest_cnt;
    int          busy_cnt;
    int          limit_cycles;
    int          n_value_err;
    int          n_timing_err;
    int          n_proto_err;
    mpa_wb_t     wb_data[$];
    int          wb_cyc[$];
    int          done_cyc[$];
    string       case_name[$];
    mpa_req_t    case_req[$];
    logic [63:0] case_exp[$];

    mpa_malu_top u_dut (
        .g_clk        (g_clk),
        .g_resetn     (g_resetn),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .wb_valid_o   (wb_valid_o),
        .wb_o         (wb_o),
        .done_o       (done_o),
        .busy_o       (busy_o),
        .dest_in_rs_o (dest_in_rs_o)
    );

    initial begin
        g_clk = 1'b0;
        forever #2 g_clk = ~g_clk;
    end

    always @(posedge g_clk) begin
        cyc <= cyc + 1;     // Edge count
    end

    // Outputs are sampled mid-cycle
    always @(negedge g_clk) begin
        if (g_resetn) begin
            if (wb_valid_o) begin
                wb_data.push_back(wb_o);
                wb_cyc.push_back(cyc);
            end
            if (done_o) begin
                done_cyc.push_back(cyc);
                if (!wb_valid_o) begin
                    $display("done_o was high in cycle %0d without a writeback", cyc);
                    n_proto_err++;
                end
            end
            if (dest_in_rs_o) begin
                dest_cnt++;
            end
            if (busy_o) begin
                busy_cnt++;
            end
        end
    end

    // Step count of each operation class
    function automatic int op_steps(input mpa_op_e op);
        case (op)
            OP_MEQU, OP_MLTE, OP_MGTE: return 1;
            OP_MADD3, OP_MSUB3, OP_MACC2, OP_MMUL1: return 3;
            default: return 2;
        endcase
    endfunction

    // Reference result of the arithmetic and shift rules
    function automatic logic [63:0] model_result(input mpa_req_t r);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        logic [63:0] src;
        logic [5:0]  amt;
        logic        reg_big;
        a       = {32'b0, r.rs1};
        b       = {32'b0, r.rs2};
        c       = {32'b0, r.rs3};
        src     = {r.rs1, r.rs2};
        amt     = (r.op == OP_MSLLI || r.op == OP_MSRLI) ? r.imm : r.rs3[5:0];
        reg_big = (r.op == OP_MSLL || r.op == OP_MSRL) && (r.rs3 >= 32'd64);
        case (r.op)
            OP_MADD2: return a + b;
            OP_MSUB2: return a - b;
            OP_MADD3: return a + b + c;
            OP_MSUB3: return a - b - c;
            OP_MACC1: return {r.rs2, r.rs3} + a;
            OP_MACC2: return {r.rs2, r.rs3} + a + b;
            OP_MMUL1: return a * b + c;
            OP_MSLL, OP_MSLLI: return reg_big ? 64'd0 : src << amt;
            OP_MSRL, OP_MSRLI: return reg_big ? 64'd0 : src >> amt;
            default: return 64'd0;
        endcase
    endfunction

    task automatic compare_wb(input string name, input mpa_wb_t exp_wb, input mpa_wb_t act_wb);
        if (act_wb !== exp_wb) begin
            $display("FAIL %s: expected ben=%h hi=%b data=%h, actual ben=%h hi=%b data=%h",
                     name, exp_wb.ben, exp_wb.word_hi, exp_wb.wdata,
                     act_wb.ben, act_wb.word_hi, act_wb.wdata);
            n_value_err++;
        end
    endtask

    task automatic compare_latency(input string name, input int exp_cyc, input int act_cyc);
        if (act_cyc != exp_cyc) begin
            $display("FAIL %s: expected %0d cycles, actual %0d", name, exp_cyc, act_cyc);
            n_timing_err++;
        end
    endtask

    task automatic send_req(input mpa_req_t req, output int start);
        @(posedge g_clk);
        req_valid_i <= 1'b1;
        req_i       <= req;
        @(posedge g_clk);
        start = cyc;                // Edge that samples the strobe
        req_valid_i <= 1'b0;
    endtask

    task automatic wait_done(input string name, input int count);
        int n;
        n = 0;
        while (done_cyc.size() < count && n < DONE_LIMIT) begin
            @(posedge g_clk);
            n++;
        end
        if (done_cyc.size() < count) begin
            $display("%s: done_o did not arrive within %0d cycles", name, DONE_LIMIT);
            n_proto_err++;
        end
    endtask

    // Pops one operation's words and done from the monitor queues
    task automatic check_result(input string name, input mpa_op_e op,
                                input logic [63:0] exp_res, input int start);
        int      steps;
        int      first;
        int      i;
        mpa_wb_t exp_wb;
        mpa_wb_t act_wb;
        steps = op_steps(op);
        first = (steps == 3) ? 2 : 1;   // Three-step ops skip step 0
        for (i = 0; i < ((steps == 1) ? 1 : 2); i++) begin
            if (wb_data.size() == 0) begin
                $display("%s: word %0d was never written back", name, i);
                n_proto_err++;
            end else begin
                act_wb         = wb_data.pop_front();
                exp_wb.ben     = 4'hf;
                exp_wb.word_hi = (i == 1);
                exp_wb.wdata   = (i == 1) ? exp_res[63:32] : exp_res[31:0];
                compare_wb(name, exp_wb, act_wb);
                compare_latency({name, " write"}, first + i, wb_cyc.pop_front() - start);
            end
        end
        if (done_cyc.size() != 0) begin
            compare_latency({name, " done"}, steps, done_cyc.pop_front() - start);
        end
    endtask

    task automatic run_case(input string name, input mpa_req_t req, input logic [63:0] exp_res);
        int start;
        dest_cnt = 0;
        busy_cnt = 0;
        send_req(req, start);
        wait_done(name, 1);
        check_result(name, req.op, exp_res, start);
        compare_latency({name, " dest_in_rs"},
                        (req.op == OP_MACC1 || req.op == OP_MACC2) ? op_steps(req.op) : 0,
                        dest_cnt);
        compare_latency({name, " busy"}, op_steps(req.op), busy_cnt);
        if (wb_data.size() != 0) begin
            $display("%s: %0d unexpected extra writeback words", name, wb_data.size());
            n_proto_err++;
        end
        wb_data.delete();
        wb_cyc.delete();
        done_cyc.delete();
    endtask

    // Strobes during busy are dropped and a strobe in the done cycle starts at once
    task automatic run_overlap();
        mpa_req_t a;
        mpa_req_t b;
        mpa_req_t junk;
        int       start_a;
        int       start_b;
        a    = '{op: OP_MADD2, rs1: 32'h89abcdef, rs2: 32'h87654321, default: '0};
        b    = '{op: OP_MSUB3, rs1: 32'h00000100, rs2: 32'h00000080, rs3: 32'h00000081,
                 default: '0};
        junk = '{op: OP_MMUL1, rs1: 32'hffffffff, rs2: 32'h00000002, rs3: 32'h00000007,
                 default: '0};
        dest_cnt = 0;
        busy_cnt = 0;
        @(posedge g_clk);
        req_valid_i <= 1'b1;
        req_i       <= a;
        @(posedge g_clk);
        start_a = cyc;
        req_i   <= junk;            // Seen during step 0 of a
        @(posedge g_clk);
        req_i   <= b;               // Seen in the done cycle of a
        @(posedge g_clk);
        start_b = cyc;
        req_valid_i <= 1'b0;
        @(posedge g_clk);
        req_valid_i <= 1'b1;
        req_i       <= junk;        // Seen during step 1 of b
        @(posedge g_clk);
        req_valid_i <= 1'b0;
        wait_done("overlap", 2);
        check_result("overlap_madd2", a.op, model_result(a), start_a);
        check_result("overlap_msub3", b.op, model_result(b), start_b);
        compare_latency("overlap dest_in_rs", 0, dest_cnt);
        compare_latency("overlap busy", op_steps(a.op) + op_steps(b.op), busy_cnt);
        repeat (4) @(posedge g_clk);
        @(negedge g_clk);
        if (wb_data.size() != 0 || done_cyc.size() != 0 || busy_o) begin
            $display("overlap: a strobe sent while busy started extra work");
            n_proto_err++;
        end
    endtask

    task automatic check_reset_idle();
        repeat (3) begin
            @(negedge g_clk);
            if (wb_valid_o !== 1'b0 || done_o !== 1'b0 || busy_o !== 1'b0 ||
                dest_in_rs_o !== 1'b0 || wb_o.ben !== 4'h0) begin
                $display("Outputs not idle after reset: wb_valid=%b done=%b busy=%b dest=%b",
                         wb_valid_o, done_o, busy_o, dest_in_rs_o);
                n_proto_err++;
            end
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          code;
        int          ch;
        string       name;
        mpa_req_t    r;
        logic [3:0]  op_v;
        logic [5:0]  imm_v;
        logic        cin_v;
        logic [31:0] rs1_v;
        logic [31:0] rs2_v;
        logic [31:0] rs3_v;
        logic [31:0] lo_v;
        logic [31:0] hi_v;
        fd = $fopen("test/mpa_malu_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open test/mpa_malu_cases.txt");
            n_proto_err++;
            return;
        end
        while (1) begin
            code = $fscanf(fd, "%s", name);
            if (code != 1) break;
            if (name.getc(0) == "#") begin
                ch = $fgetc(fd);    // Skip the rest of a comment line
                while (ch != 10 && ch != -1) ch = $fgetc(fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h %h %h %h %h",
                               op_v, rs1_v, rs2_v, rs3_v, imm_v, cin_v, lo_v, hi_v);
                if (code != 8) begin
                    $display("Case %s in the case file is malformed", name);
                    n_proto_err++;
                    break;
                end
                r = '{op: mpa_op_e'(op_v), rs1: rs1_v, rs2: rs2_v, rs3: rs3_v,
                      imm: imm_v, carry_in: cin_v};
                case_name.push_back(name);
                case_req.push_back(r);
                case_exp.push_back({hi_v, lo_v});
            end
        end
        $fclose(fd);
    endtask

    initial begin
        wait (limit_cycles != 0);
        repeat (limit_cycles) @(posedge g_clk);
        $display("Watchdog expired after %0d cycles, the run is stuck", limit_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        mpa_req_t    r;
        mpa_op_e     rand_ops[$];
        int unsigned seed_ret;
        int          i;
        seed_ret    = $urandom(SEED);
        g_resetn    = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        rand_ops    = '{OP_MADD2, OP_MSUB2, OP_MADD3, OP_MSUB3, OP_MACC1, OP_MACC2,
                        OP_MMUL1, OP_MSLL, OP_MSLLI, OP_MSRL, OP_MSRLI};
        load_cases();
        limit_cycles = (case_name.size() + N_RAND + 2) * 10 + RESET_CYCLES;
        repeat (RESET_CYCLES) @(posedge g_clk);
        g_resetn <= 1'b1;
        check_reset_idle();
        for (i = 0; i < case_name.size(); i++) begin
            run_case(case_name[i], case_req[i], case_exp[i]);
        end
        run_overlap();
        for (i = 0; i < N_RAND; i++) begin
            r     = '0;
            r.op  = rand_ops[$urandom % rand_ops.size()];
            r.rs1 = $urandom;
            r.rs2 = $urandom;
            r.rs3 = ($urandom % 4 == 0) ? $urandom : $urandom % 72;  // Mostly in-range amounts
            r.imm = 6'($urandom);
            run_case($sformatf("rand_%0d_%s", i, r.op.name()), r, model_result(r));
        end
        repeat (2) @(posedge g_clk);
        $display("Errors: value %0d, timing %0d, protocol %0d",
                 n_value_err, n_timing_err, n_proto_err);
        if (n_value_err + n_timing_err + n_proto_err == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== mpa_malu_top.f ====
source/mpa_pkg.sv
source/mpa_sequencer.sv
source/mpa_arith_unit.sv
source/mpa_shift_cmp_unit.sv
source/mpa_writeback.sv
source/mpa_malu_top.sv
test/mpa_malu_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := mpa_malu_tb
FILELIST  := mpa_malu_top.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== test/mpa_malu_cases.txt ====
# name op rs1 rs2 rs3 imm carry_in exp_lo exp_hi, all fields after the name in hex
# op 0 mequ 1 mlte 2 mgte 3 madd2 4 madd3 5 msub2 6 msub3 7 macc1 8 macc2 9 mmul1 a-d shifts
mequ_eq_c1   0 00000000 12345678 12345678 00 1 00000001 00000000
mequ_eq_c0   0 00000000 12345678 12345678 00 0 00000000 00000000
mequ_ne      0 00000000 00000001 00000002 00 1 00000000 00000000
mlte_lt      1 00000000 00000005 00000009 00 0 00000001 00000000
mlte_gt      1 00000000 ffffffff 7fffffff 00 1 00000000 00000000
mlte_eq_c1   1 00000000 deadbeef deadbeef 00 1 00000001 00000000
mgte_gt      2 00000000 80000000 7fffffff 00 0 00000001 00000000
mgte_lt      2 00000000 00000001 00000002 00 1 00000000 00000000
mgte_eq_c1   2 00000000 00000000 00000000 00 1 00000001 00000000
mgte_eq_c0   2 00000000 00000000 00000000 00 0 00000000 00000000
madd2_carry  3 ffffffff 00000001 00000000 00 0 00000000 00000001
madd2_max    3 ffffffff ffffffff 00000000 00 0 fffffffe 00000001
msub2_pos    5 00000010 00000003 00000000 00 0 0000000d 00000000
msub2_borrow 5 00000000 00000001 00000000 00 0 ffffffff ffffffff
madd3_carry  4 ffffffff ffffffff ffffffff 00 0 fffffffd 00000002
msub3_borrow 6 00000005 00000003 00000004 00 0 fffffffe ffffffff
macc1_carry  7 00000001 00000000 ffffffff 00 0 00000000 00000001
macc1_wrap   7 00000002 ffffffff ffffffff 00 0 00000001 00000000
macc2_basic  8 00000010 00000001 00000020 00 0 00000031 00000001
macc2_carry  8 ffffffff ffffffff 00000000 00 0 fffffffe 00000000
mmul1_max    9 ffffffff ffffffff ffffffff 00 0 00000000 ffffffff
mmul1_basic  9 00010000 00010000 00000005 00 0 00000005 00000001
msll_reg     a 00000001 80000000 00000004 00 0 00000000 00000018
msll_reg_big a 00000001 80000000 00000100 00 0 00000000 00000000
mslli_32     b aaaaaaaa 12345678 ffffffff 20 0 00000000 12345678
mslli_1      b 80000000 80000001 00000000 01 0 00000002 00000001
msrl_reg     c 12345678 9abcdef0 00000008 00 0 789abcde 00123456
msrl_reg_65  c 80000000 00000000 00000041 00 0 00000000 00000000
msrli_4      d 0000000f 00000000 00000000 04 0 f0000000 00000000
msrli_0      d cafef00d 0badc0de ffffffff 00 0 0badc0de cafef00d
